//--- hw/usb_serial_macros.svh
// usb serial sizing macros
`ifndef USB_SERIAL_MACROS_SVH
`define USB_SERIAL_MACROS_SVH

// log2 of per-channel send buffer depth
`define USB_SEND_ASIZE 4

// data bytes per IN packet, at most
`define USB_IN_MAXPKT 8

`endif

//--- hw/usb_serial_pkg.sv
// usb serial shared types
`default_nettype none

package usb_serial_pkg;

    // --------------------
    // channel and token types
    typedef logic chan_t;                 // 0 or 1

    typedef struct packed {
        chan_t chan;                      // IN endpoint addressed by host
    } in_token_t;

    // --------------------
    // IN packet records
    typedef struct packed {
        chan_t      chan;                 // source channel
        logic [7:0] data;                 // payload byte
    } pkt_byte_t;

    typedef struct packed {
        chan_t chan;                      // channel of finished packet
        logic  toggle;                    // DATA0 / DATA1
        logic  zlp;                       // no data bytes in packet
    } pkt_end_t;

    // --------------------
    // OUT packet start
    typedef struct packed {
        chan_t chan;                      // target channel
        logic  toggle;                    // received data pid toggle
    } out_pid_t;

endpackage

`default_nettype wire

//--- hw/send_fifo.sv
// per-channel send buffer
`timescale 1ns/1ns
`default_nettype none

`include "usb_serial_macros.svh"

module send_fifo (
    input  wire logic       clk,
    input  wire logic       usb_rstn,
    // application write side
    input  wire logic [7:0] send_data,
    input  wire logic       send_valid,
    output logic            send_ready,
    // packetizer read side
    input  wire logic       rd_pop,
    output logic      [7:0] rd_data,
    output logic            rd_valid
);

    localparam int ASIZE = `USB_SEND_ASIZE;
    localparam int DEPTH = 1 << ASIZE;

    logic [7:0]   mem [0:DEPTH-1];         // byte storage, no reset
    logic [ASIZE:0] wptr;                  // extra msb marks wrap
    logic [ASIZE:0] rptr;
    logic [ASIZE:0] rptr_nxt;              // read pointer after this cycle's pop
    logic           wr_en;
    logic           pop_en;

    // --------------------
    // write side
    assign send_ready = (wptr != {~rptr[ASIZE], rptr[ASIZE-1:0]});  // low only when full
    assign wr_en      = send_valid & send_ready;

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            wptr <= '0;
        end else if (wr_en) begin
            wptr <= wptr + 1'b1;               // advance on handshake
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wptr[ASIZE-1:0]] <= send_data;
        end
    end

    // --------------------
    // show-ahead read side
    assign pop_en   = rd_pop & rd_valid;       // pop of an empty head is ignored
    assign rptr_nxt = rptr + {{ASIZE{1'b0}}, pop_en};

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            rptr     <= '0;
            rd_valid <= 1'b0;
        end else begin
            rptr     <= rptr_nxt;
            rd_valid <= (wptr != rptr_nxt);    // head valid once byte settled
        end
    end

    // head byte already reflects the pop
    always_ff @(posedge clk) begin
        rd_data <= mem[rptr_nxt[ASIZE-1:0]];
    end

endmodule

`default_nettype wire

//--- hw/in_packetizer.sv
// IN endpoint packetizer
`timescale 1ns/1ns
`default_nettype none

`include "usb_serial_macros.svh"

module in_packetizer
    import usb_serial_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            usb_rstn,
    // host token / handshake
    input  wire in_token_t       in_tok,
    input  wire logic            in_tok_stb,
    input  wire chan_t           ack,
    input  wire logic            ack_stb,
    // send buffer heads
    input  wire logic [1:0]      rd_valid,
    input  wire logic [1:0][7:0] rd_data,
    output logic      [1:0]      rd_pop,
    // packet out
    output pkt_byte_t            tx_byte,
    output logic                 tx_byte_stb,
    output pkt_end_t             tx_end,
    output logic                 tx_end_stb
);

    localparam int MAXPKT = `USB_IN_MAXPKT;
    localparam int CNT_W  = $clog2(MAXPKT + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LATCH,
        S_STREAM,
        S_FINISH
    } state_t;

    state_t           state;
    chan_t            chan;                // channel being served
    logic [CNT_W-1:0] cnt;                 // bytes sent in this packet
    logic [1:0]       in_toggle;           // per-channel IN data toggle
    logic             emit;
    logic             cnt_last;

    // --------------------
    // byte emission
    assign emit     = (state == S_STREAM) && rd_valid[chan];
    assign cnt_last = (cnt == CNT_W'(MAXPKT - 1));    // this byte fills the packet

    always_comb begin
        rd_pop        = '0;
        rd_pop[chan]  = emit;                  // one pop per emitted byte
        tx_byte_stb   = emit;
        tx_byte.chan  = chan;
        tx_byte.data  = rd_data[chan];         // show-ahead head byte
        tx_end_stb    = (state == S_FINISH);
        tx_end.chan   = chan;
        tx_end.toggle = in_toggle[chan];
        tx_end.zlp    = (cnt == '0);           // nothing sent
    end

    // --------------------
    // control FSM
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            state <= S_IDLE;
            chan  <= 1'b0;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_tok_stb) begin      // busy tokens dropped elsewhere
                        chan  <= in_tok.chan;
                        cnt   <= '0;
                        state <= S_LATCH;
                    end
                end
                S_LATCH: begin
                    // empty buffer goes straight to a zero-length packet
                    state <= rd_valid[chan] ? S_STREAM : S_FINISH;
                end
                S_STREAM: begin
                    if (emit) begin
                        cnt <= cnt + 1'b1;
                        if (cnt_last) begin
                            state <= S_FINISH;  // max packet size reached
                        end
                    end else begin
                        state <= S_FINISH;      // buffer ran dry
                    end
                end
                S_FINISH: begin
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // --------------------
    // IN toggles, flipped by host ack
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            in_toggle <= '0;
        end else if (ack_stb) begin
            in_toggle[ack] <= ~in_toggle[ack];
        end
    end

endmodule

`default_nettype wire

//--- hw/out_receiver.sv
// OUT endpoint receiver
`timescale 1ns/1ns
`default_nettype none

module out_receiver
    import usb_serial_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       usb_rstn,
    // host OUT packet
    input  wire out_pid_t   out_start,
    input  wire logic       out_start_stb,
    input  wire logic [7:0] out_data,
    input  wire logic       out_data_stb,
    input  wire logic       out_end_stb,
    // application receive side
    output logic      [7:0] recv_data,
    output logic      [1:0] recv_valid
);

    logic [1:0] exp_toggle;                // expected toggle per channel
    chan_t      cur_chan;                  // channel of current packet
    logic       accept;                    // current packet is not a duplicate

    // --------------------
    // packet state
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            exp_toggle <= '0;
            cur_chan   <= 1'b0;
            accept     <= 1'b0;
        end else begin
            if (out_start_stb) begin
                cur_chan <= out_start.chan;
                accept   <= (out_start.toggle == exp_toggle[out_start.chan]);
            end else if (out_end_stb) begin
                accept <= 1'b0;
                if (accept) begin
                    exp_toggle[cur_chan] <= ~exp_toggle[cur_chan];  // good packet done
                end
            end
        end
    end

    // --------------------
    // byte routing
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            recv_valid <= '0;
        end else begin
            recv_valid           <= '0;                   // single-cycle strobe
            recv_valid[cur_chan] <= out_data_stb & accept;
        end
    end

    always_ff @(posedge clk) begin
        if (out_data_stb && accept) begin
            recv_data <= out_data;             // shared between channels
        end
    end

endmodule

`default_nettype wire

//--- hw/usb_serial2_top.sv
// two-channel usb serial data path
`timescale 1ns/1ns
`default_nettype none

module usb_serial2_top
    import usb_serial_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            usb_rstn,
    // application send path
    input  wire logic [1:0][7:0] send_data,
    input  wire logic [1:0]      send_valid,
    output logic      [1:0]      send_ready,
    // IN endpoint
    input  wire in_token_t       in_tok,
    input  wire logic            in_tok_stb,
    input  wire chan_t           ack,
    input  wire logic            ack_stb,
    output pkt_byte_t            tx_byte,
    output logic                 tx_byte_stb,
    output pkt_end_t             tx_end,
    output logic                 tx_end_stb,
    // OUT endpoint
    input  wire out_pid_t        out_start,
    input  wire logic            out_start_stb,
    input  wire logic [7:0]      out_data,
    input  wire logic            out_data_stb,
    input  wire logic            out_end_stb,
    output logic      [7:0]      recv_data,
    output logic      [1:0]      recv_valid
);

    logic [1:0]      rd_valid;             // buffer heads toward packetizer
    logic [1:0][7:0] rd_data;
    logic [1:0]      rd_pop;

    // --------------------
    // send buffers, one per channel
    for (genvar ch = 0; ch < 2; ch++) begin : g_send
        send_fifo i_send_fifo (
            .clk        (clk),
            .usb_rstn   (usb_rstn),
            .send_data  (send_data[ch]),
            .send_valid (send_valid[ch]),
            .send_ready (send_ready[ch]),
            .rd_pop     (rd_pop[ch]),
            .rd_data    (rd_data[ch]),
            .rd_valid   (rd_valid[ch])
        );
    end

    // --------------------
    // IN side
    in_packetizer i_in_packetizer (
        .clk         (clk),
        .usb_rstn    (usb_rstn),
        .in_tok      (in_tok),
        .in_tok_stb  (in_tok_stb),
        .ack         (ack),
        .ack_stb     (ack_stb),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_pop      (rd_pop),
        .tx_byte     (tx_byte),
        .tx_byte_stb (tx_byte_stb),
        .tx_end      (tx_end),
        .tx_end_stb  (tx_end_stb)
    );

    // --------------------
    // OUT side
    out_receiver i_out_receiver (
        .clk           (clk),
        .usb_rstn      (usb_rstn),
        .out_start     (out_start),
        .out_start_stb (out_start_stb),
        .out_data      (out_data),
        .out_data_stb  (out_data_stb),
        .out_end_stb   (out_end_stb),
        .recv_data     (recv_data),
        .recv_valid    (recv_valid)
    );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic usb_rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        usb_rstn = 1'b0;                       // held low from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        usb_rstn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/usb_serial2_checker.sv
// usb serial port assertions
`timescale 1ns/1ns
`default_nettype none

module usb_serial2_checker
    import usb_serial_pkg::*;
(
    input wire logic       clk,
    input wire logic       usb_rstn,
    input wire logic [1:0] send_valid,
    input wire logic [1:0] send_ready,
    input wire pkt_byte_t  tx_byte,
    input wire logic       tx_byte_stb,
    input wire logic       tx_end_stb,
    input wire logic [1:0] recv_valid
);

    int unsigned fail_cnt = 0;                 // read by the testbench at the end

    // --------------------
    // first cycle out of reset
    a_reset_state: assert property (@(posedge clk)
        $rose(usb_rstn) |-> (!tx_byte_stb && !tx_end_stb && recv_valid == 2'b00
                             && send_ready == 2'b11))
        else begin
            $error("outputs not in reset state after reset release");
            fail_cnt++;
        end

    // --------------------
    // send buffer back-pressure
    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        // full stays full while nothing leaves the buffer
        a_full_holds: assert property (@(posedge clk) disable iff (!usb_rstn)
            (send_valid[ch] && !send_ready[ch] && !(tx_byte_stb && tx_byte.chan == ch))
            |=> !send_ready[ch])
            else begin
                $error("send buffer took a byte while send_ready was low");
                fail_cnt++;
            end

        a_room_from_pop: assert property (@(posedge clk) disable iff (!usb_rstn)
            $rose(send_ready[ch]) |-> $past(tx_byte_stb && tx_byte.chan == ch))
            else begin
                $error("send_ready rose without a byte leaving the buffer");
                fail_cnt++;
            end
    end

    // --------------------
    // strobe exclusivity
    a_recv_one_chan: assert property (@(posedge clk) disable iff (!usb_rstn)
        $onehot0(recv_valid))
        else begin
            $error("recv_valid strobed on both channels at once");
            fail_cnt++;
        end

    a_byte_or_end: assert property (@(posedge clk) disable iff (!usb_rstn)
        !(tx_byte_stb && tx_end_stb))
        else begin
            $error("tx_byte_stb and tx_end_stb high together");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- verification/usb_serial2_tb.sv
// two-channel usb serial testbench
`timescale 1ns/1ns
`default_nettype none

`include "usb_serial_macros.svh"

module usb_serial2_tb
    import usb_serial_pkg::*;
();

    localparam int MAXPKT = `USB_IN_MAXPKT;
    localparam int DEPTH  = 1 << `USB_SEND_ASIZE;
    localparam int LIMIT  = 2 * (30 + 80 + 30 + 100 + 60 + 100);  // per-test estimates

    logic            clk;
    logic            usb_rstn;
    logic [1:0][7:0] send_data;
    logic [1:0]      send_valid;
    logic [1:0]      send_ready;
    in_token_t       in_tok;
    logic            in_tok_stb;
    chan_t           ack;
    logic            ack_stb;
    pkt_byte_t       tx_byte;
    logic            tx_byte_stb;
    pkt_end_t        tx_end;
    logic            tx_end_stb;
    out_pid_t        out_start;
    logic            out_start_stb;
    logic [7:0]      out_data;
    logic            out_data_stb;
    logic            out_end_stb;
    logic [7:0]      recv_data;
    logic [1:0]      recv_valid;

    // reference model state
    logic [7:0] exp_q [2][$];                  // bytes accepted, not yet sent
    logic [1:0] in_tog_m  = '0;
    logic [1:0] out_tog_m = '0;
    logic       busy_m    = 1'b0;              // IN packet in flight
    logic       first_m   = 1'b0;
    logic       acc_m     = 1'b0;              // current OUT packet accepted
    chan_t      pkt_ch_m  = 1'b0;
    chan_t      out_ch_m  = 1'b0;
    int         pkt_cnt_m = 0;
    int         tok_cyc_m = 0;
    int         mon_cyc   = 0;
    logic [1:0] rv_pend   = '0;                // recv strobe due next edge
    logic [7:0] rd_pend   = '0;
    int         ends_seen = 0;
    int         last_cnt  = 0;
    logic       last_tog  = 1'b0;
    logic       last_zlp  = 1'b0;
    int         acc_cnt [2] = '{0, 0};
    int         recv_cnt [2] = '{0, 0};
    int         err_cnt   = 0;
    int         cyc       = 0;
    string      test_name = "reset";

    tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(8)) i_clk_gen (
        .clk      (clk),
        .usb_rstn (usb_rstn)
    );

    usb_serial2_top i_dut (.*);

    bind usb_serial2_top usb_serial2_checker i_checker (
        .clk         (clk),
        .usb_rstn    (usb_rstn),
        .send_valid  (send_valid),
        .send_ready  (send_ready),
        .tx_byte     (tx_byte),
        .tx_byte_stb (tx_byte_stb),
        .tx_end_stb  (tx_end_stb),
        .recv_valid  (recv_valid)
    );

    task automatic check_val(input string what, input int exp, input int act);
        assert (exp == act) else begin
            err_cnt++;
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    // --------------------
    // monitor and reference model
    always @(posedge clk) begin : monitor
        logic [7:0] exp_b;
        if (usb_rstn) begin
            mon_cyc++;
            for (int ch = 0; ch < 2; ch++) begin
                if (send_valid[ch] && send_ready[ch]) begin
                    exp_q[ch].push_back(send_data[ch]);    // handshake = accepted
                    acc_cnt[ch]++;
                end
                if (recv_valid[ch]) recv_cnt[ch]++;
            end
            if (in_tok_stb && !busy_m) begin               // busy tokens are dropped
                busy_m    = 1'b1;
                pkt_ch_m  = in_tok.chan;
                pkt_cnt_m = 0;
                tok_cyc_m = mon_cyc;
                first_m   = 1'b1;
            end
            if ((tx_byte_stb || tx_end_stb) && first_m) begin
                check_val("first response latency", 2, mon_cyc - tok_cyc_m);
                first_m = 1'b0;
            end
            if ((tx_byte_stb || tx_end_stb) && !busy_m) begin
                err_cnt++;
                $display("IN packet output appeared with no token pending");
            end
            if (tx_byte_stb) begin
                check_val("byte channel", pkt_ch_m, tx_byte.chan);
                if (exp_q[pkt_ch_m].size() == 0) begin
                    err_cnt++;
                    $display("byte sent from a channel with nothing queued");
                end else begin
                    exp_b = exp_q[pkt_ch_m].pop_front();
                    check_val("byte", exp_b, tx_byte.data);
                end
                pkt_cnt_m++;
            end
            if (tx_end_stb) begin
                check_val("end channel", pkt_ch_m, tx_end.chan);
                check_val("end toggle", in_tog_m[pkt_ch_m], tx_end.toggle);
                check_val("end zlp", pkt_cnt_m == 0, tx_end.zlp);
                check_val("packet within max size", 1, pkt_cnt_m <= MAXPKT);
                if (pkt_cnt_m < MAXPKT) begin
                    check_val("bytes left after short packet", 0, exp_q[pkt_ch_m].size());
                end
                last_cnt = pkt_cnt_m;
                last_tog = tx_end.toggle;
                last_zlp = tx_end.zlp;
                busy_m   = 1'b0;
                ends_seen++;
            end
            if (ack_stb) in_tog_m[ack] = ~in_tog_m[ack];  // after end check
            // OUT side, one cycle from strobe to recv
            check_val("recv valid", rv_pend, recv_valid);
            if (rv_pend != 2'b00) check_val("recv data", rd_pend, recv_data);
            rv_pend = '0;
            if (out_data_stb && acc_m) begin
                rv_pend[out_ch_m] = 1'b1;
                rd_pend           = out_data;
            end
            if (out_start_stb) begin
                out_ch_m = out_start.chan;
                acc_m    = (out_start.toggle == out_tog_m[out_start.chan]);
            end else if (out_end_stb) begin
                if (acc_m) out_tog_m[out_ch_m] = ~out_tog_m[out_ch_m];
                acc_m = 1'b0;
            end
        end
    end

    // --------------------
    // stimulus tasks, called just after a rising edge
    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic write_bytes(input int ch, input int n);
        for (int i = 0; i < n; i++) begin
            send_data[ch]  <= 8'($urandom);
            send_valid[ch] <= 1'b1;
            do @(posedge clk); while (!send_ready[ch]);
        end
        send_valid[ch] <= 1'b0;
    endtask

    task automatic in_packet(input int ch);
        int base;
        base = ends_seen;
        in_tok.chan <= ch[0];
        in_tok_stb  <= 1'b1;
        @(posedge clk);
        in_tok_stb  <= 1'b0;
        while (ends_seen == base) @(posedge clk);   // end strobe closes packet
    endtask

    task automatic send_ack(input int ch);
        ack     <= ch[0];
        ack_stb <= 1'b1;
        @(posedge clk);
        ack_stb <= 1'b0;
    endtask

    task automatic out_packet(input int ch, input logic tog, input int n);
        out_start.chan   <= ch[0];
        out_start.toggle <= tog;
        out_start_stb    <= 1'b1;
        @(posedge clk);
        out_start_stb    <= 1'b0;
        for (int i = 0; i < n; i++) begin
            out_data     <= 8'($urandom);
            out_data_stb <= 1'b1;
            @(posedge clk);
        end
        out_data_stb <= 1'b0;
        out_end_stb  <= 1'b1;
        @(posedge clk);
        out_end_stb  <= 1'b0;
    endtask

    // --------------------
    // run limit
    always @(posedge clk) begin
        cyc++;
        if (cyc >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // --------------------
    // test sequence
    initial begin
        int   base;
        int   total;
        void'($urandom(53251));
        send_data     = '0;
        send_valid    = '0;
        in_tok        = '0;
        in_tok_stb    = 1'b0;
        ack           = 1'b0;
        ack_stb       = 1'b0;
        out_start     = '0;
        out_start_stb = 1'b0;
        out_data      = '0;
        out_data_stb  = 1'b0;
        out_end_stb   = 1'b0;
        wait (usb_rstn);
        @(posedge clk);
        idle(4);                               // reset state checked by checker

        test_name = "in_split";
        write_bytes(0, 11);
        idle(2);
        in_packet(0);
        check_val("packet 1 size", MAXPKT, last_cnt);
        check_val("packet 1 toggle", 0, last_tog);
        send_ack(0);
        in_packet(0);
        check_val("packet 2 size", 3, last_cnt);
        check_val("packet 2 toggle", 1, last_tog);
        send_ack(0);

        test_name = "zero_length";
        in_packet(0);
        check_val("zlp flag", 1, last_zlp);
        check_val("zlp size", 0, last_cnt);
        check_val("zlp toggle", 0, last_tog);  // two acks so far
        in_packet(0);                          // no ack, same toggle
        check_val("repeat toggle", 0, last_tog);
        check_val("repeat zlp flag", 1, last_zlp);

        test_name = "back_pressure";
        base = acc_cnt[1];
        send_data[1]  <= 8'($urandom);
        send_valid[1] <= 1'b1;
        repeat (DEPTH + 8) begin
            @(posedge clk);
            if (send_ready[1]) send_data[1] <= 8'($urandom);
        end
        send_valid[1] <= 1'b0;
        idle(1);
        check_val("accepted bytes", DEPTH, acc_cnt[1] - base);
        check_val("ready when full", 0, send_ready[1]);
        in_packet(1);
        check_val("pops after token", MAXPKT, last_cnt);
        idle(2);
        check_val("ready after pops", 1, send_ready[1]);
        send_ack(1);
        in_packet(1);                          // drain the rest
        send_ack(1);

        test_name = "out_filter";
        base = recv_cnt[1];
        out_packet(1, 1'b0, 4);
        idle(2);
        check_val("first packet bytes", 4, recv_cnt[1] - base);
        base = recv_cnt[1];
        out_packet(1, 1'b0, 4);                // duplicate
        idle(2);
        check_val("duplicate bytes", 0, recv_cnt[1] - base);
        base = recv_cnt[1];
        out_packet(1, 1'b1, 5);
        idle(2);
        check_val("third packet bytes", 5, recv_cnt[1] - base);

        test_name = "chan_mix";
        base = recv_cnt[0];
        fork
            write_bytes(0, 6);
            write_bytes(1, 5);
            begin
                out_packet(0, 1'b0, 3);
                out_packet(1, 1'b0, 4);
                out_packet(0, 1'b0, 2);        // duplicate on ch0
                out_packet(1, 1'b1, 3);
            end
        join
        idle(2);
        check_val("ch0 recv bytes", 3, recv_cnt[0] - base);
        in_packet(1);
        send_ack(1);
        in_packet(0);
        send_ack(0);
        in_packet(1);                          // ch1 now empty
        check_val("ch1 drained zlp", 1, last_zlp);
        check_val("ch0 leftover", 0, exp_q[0].size());
        check_val("ch1 leftover", 0, exp_q[1].size());

        idle(4);
        total = err_cnt + int'(i_dut.i_checker.fail_cnt);
        $display("error counts: %0d model mismatches, %0d assertion failures",
                 err_cnt, i_dut.i_checker.fail_cnt);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/usb_serial_pkg.sv
hw/send_fifo.sv
hw/in_packetizer.sv
hw/out_receiver.sv
hw/usb_serial2_top.sv
verification/tb_clk_gen.sv
verification/usb_serial2_checker.sv
verification/usb_serial2_tb.sv

//--- Bender.yml
package:
  name: usb_serial2

sources:
  - include_dirs:
      - hw
    files:
      - hw/usb_serial_pkg.sv
      - hw/send_fifo.sv
      - hw/in_packetizer.sv
      - hw/out_receiver.sv
      - hw/usb_serial2_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/tb_clk_gen.sv
      - verification/usb_serial2_checker.sv
      - verification/usb_serial2_tb.sv
